// ==== logic/rename_settings.svh ====
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// ==================================================
// rename core sizing
// ==================================================

// slots renamed or retired per cycle.
`define RENAME_WIDTH 3

// architectural register file size.
`define ARCH_REGS 32

// physical register file size.
`define PHYS_REGS 64

// ==================================================
// derived sizes
// ==================================================

// every architectural register always holds one physical register,
// so only the remainder can ever sit in the free list.
`define FREE_DEPTH (`PHYS_REGS - `ARCH_REGS)

`endif

// ==== logic/rename_pkg.sv ====
`include "rename_settings.svh"

package rename_pkg;

    // ==================================================
    // register indices and counts
    // ==================================================

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(`RENAME_WIDTH + 1)-1:0] slot_count_t;  // 0 to 3 slots.

    // ==================================================
    // dispatch side
    // ==================================================

    // valid bits are packed from slot 0 upward.
    typedef struct packed {
        logic [`RENAME_WIDTH-1:0]      valid;
        arch_reg_t [`RENAME_WIDTH-1:0] dest;
    } rename_req_t;

    typedef struct packed {
        phys_reg_t new_reg;   // register taken from the free list.
        phys_reg_t prev_reg;  // mapping displaced by this slot.
    } grant_slot_t;

    typedef struct packed {
        slot_count_t                     count;
        grant_slot_t [`RENAME_WIDTH-1:0] slot;
    } rename_grant_t;

    // number of set bits in a slot valid vector.
    function automatic slot_count_t count_valid(input logic [`RENAME_WIDTH-1:0] valid);
        slot_count_t n;
        n = '0;
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            n = n + slot_count_t'(valid[k]);
        end
        return n;
    endfunction

endpackage

// ==== logic/retire_pkg.sv ====
`include "rename_settings.svh"

package retire_pkg;

    // ==================================================
    // retire side
    // ==================================================

    typedef struct packed {
        rename_pkg::arch_reg_t arch;  // destination of the retiring instruction.
        rename_pkg::phys_reg_t phys;  // register it was renamed to.
    } retire_slot_t;

    // valid bits are packed from slot 0 upward, oldest first.
    typedef struct packed {
        logic [`RENAME_WIDTH-1:0]         valid;
        retire_slot_t [`RENAME_WIDTH-1:0] slot;
    } retire_rec_t;

    // registers handed back to the free list, in retirement order.
    typedef struct packed {
        rename_pkg::slot_count_t                     count;
        rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0]   regs;
    } free_push_t;

endpackage

// ==== logic/free_list.sv ====
`timescale 1ns/1ps

`include "rename_settings.svh"

module free_list (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rename_pkg::slot_count_t                   req_count,
    input  logic                                      recover,
    input  retire_pkg::free_push_t                    push,
    output rename_pkg::slot_count_t                   grant_count,
    output rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] free_regs,
    output logic [$clog2(`FREE_DEPTH):0]              free_count
);

    // pointers carry one wrap bit above the entry index.
    localparam int PTR_W = $clog2(`FREE_DEPTH) + 1;
    localparam int IDX_W = PTR_W - 1;

    rename_pkg::phys_reg_t entries [`FREE_DEPTH];

    logic [PTR_W-1:0] head;        // oldest free entry.
    logic [PTR_W-1:0] tail;        // next entry to be written.
    logic [PTR_W-1:0] commit_ptr;  // head as seen by retired state.

    assign free_count = tail - head;

    // ==================================================
    // allocation
    // ==================================================

    // grant as many slots as are free, and none while recovering.
    always_comb begin
        if (recover) begin
            grant_count = '0;
        end else if (free_count < req_count) begin
            grant_count = rename_pkg::slot_count_t'(free_count);
        end else begin
            grant_count = req_count;
        end
    end

    for (genvar k = 0; k < `RENAME_WIDTH; k++) begin : g_read
        assign free_regs[k] = entries[head[IDX_W-1:0] + IDX_W'(k)];
    end

    // ==================================================
    // pointer state
    // ==================================================

    always_ff @(posedge clock) begin
        if (reset) begin
            head       <= '0;
            tail       <= PTR_W'(`FREE_DEPTH);  // starts full.
            commit_ptr <= '0;
        end else begin
            // recovery hands back everything allocated since the last retirement.
            if (recover) begin
                head <= commit_ptr;
            end else begin
                head <= head + PTR_W'(grant_count);
            end
            tail       <= tail + PTR_W'(push.count);
            commit_ptr <= commit_ptr + PTR_W'(push.count);  // one retirement per push.
        end
    end

    // the list initially holds every register above the architectural ones.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `FREE_DEPTH; i++) begin
                entries[i] <= rename_pkg::phys_reg_t'(`ARCH_REGS + i);
            end
        end else begin
            for (int k = 0; k < `RENAME_WIDTH; k++) begin
                if (k < push.count) begin
                    entries[tail[IDX_W-1:0] + IDX_W'(k)] <= push.regs[k];
                end
            end
        end
    end

    // ==================================================
    // checks
    // ==================================================

    // retirement can only return registers that were allocated earlier.
    a_occupancy: assert property (
        @(posedge clock) disable iff (reset)
        (push.count != '0) |=> (free_count <= `FREE_DEPTH)
    );

    a_no_push_on_recover: assert property (
        @(posedge clock) disable iff (reset)
        recover |-> (push.count == '0)
    );

endmodule

// ==== logic/commit_map.sv ====
`timescale 1ns/1ps

`include "rename_settings.svh"

module commit_map (
    input  logic                                   clock,
    input  logic                                   reset,
    input  retire_pkg::retire_rec_t                retire,
    output retire_pkg::free_push_t                 freed,
    output rename_pkg::phys_reg_t [`ARCH_REGS-1:0] arch_table
);

    // ==================================================
    // displaced registers
    // ==================================================

    // a slot displaces whatever an older slot in the same group just committed.
    always_comb begin
        freed.count = rename_pkg::count_valid(retire.valid);
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            freed.regs[k] = arch_table[retire.slot[k].arch];
            for (int j = 0; j < k; j++) begin
                if (retire.valid[j] && retire.slot[j].arch == retire.slot[k].arch) begin
                    freed.regs[k] = retire.slot[j].phys;
                end
            end
        end
    end

    // ==================================================
    // retired mapping
    // ==================================================

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                arch_table[i] <= rename_pkg::phys_reg_t'(i);  // identity map.
            end
        end else begin
            // younger slots are written last and win.
            for (int k = 0; k < `RENAME_WIDTH; k++) begin
                if (retire.valid[k]) begin
                    arch_table[retire.slot[k].arch] <= retire.slot[k].phys;
                end
            end
        end
    end

endmodule

// ==== logic/rename_map.sv ====
`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_map (
    input  logic                                      clock,
    input  logic                                      reset,
    input  rename_pkg::rename_req_t                   req,
    input  rename_pkg::slot_count_t                   grant_count,
    input  rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] free_regs,
    input  logic                                      recover,
    input  rename_pkg::phys_reg_t [`ARCH_REGS-1:0]    arch_table,
    output rename_pkg::rename_grant_t                 grant
);

    rename_pkg::phys_reg_t [`ARCH_REGS-1:0] map_table;
    logic [`RENAME_WIDTH-1:0]               renamed;  // slot got a register this cycle.

    // grants are always a prefix of the request.
    always_comb begin
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            renamed[k] = (k < grant_count);
        end
    end

    // ==================================================
    // grant and previous mapping
    // ==================================================

    always_comb begin
        grant.count = grant_count;
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            grant.slot[k].new_reg  = free_regs[k];
            grant.slot[k].prev_reg = map_table[req.dest[k]];
            // the latest older slot with the same destination takes precedence.
            for (int j = 0; j < k; j++) begin
                if (renamed[j] && req.dest[j] == req.dest[k]) begin
                    grant.slot[k].prev_reg = free_regs[j];
                end
            end
        end
    end

    // ==================================================
    // speculative mapping
    // ==================================================

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_table[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (recover) begin
            map_table <= arch_table;  // drop every speculative mapping.
        end else begin
            for (int k = 0; k < `RENAME_WIDTH; k++) begin
                if (renamed[k]) begin
                    map_table[req.dest[k]] <= free_regs[k];
                end
            end
        end
    end

    // valid slots must be packed, or the prefix grant would skip one.
    a_req_packed: assert property (
        @(posedge clock) disable iff (reset)
        ((req.valid & (req.valid + 1'b1)) == '0)
    );

endmodule

// ==== logic/rename_unit.sv ====
`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_unit (
    input  logic                         clock,
    input  logic                         reset,
    input  rename_pkg::rename_req_t      req,
    input  retire_pkg::retire_rec_t      retire,
    input  logic                         recover,
    output rename_pkg::rename_grant_t    grant,
    output logic [$clog2(`FREE_DEPTH):0] free_count
);

    rename_pkg::slot_count_t                   req_count;
    rename_pkg::slot_count_t                   grant_count;
    rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] free_regs;
    retire_pkg::free_push_t                    freed;
    rename_pkg::phys_reg_t [`ARCH_REGS-1:0]    arch_table;

    assign req_count = rename_pkg::count_valid(req.valid);

    // ==================================================
    // retire, free list and dispatch
    // ==================================================

    commit_map u_commit_map (
        .clock      (clock),
        .reset      (reset),
        .retire     (retire),
        .freed      (freed),
        .arch_table (arch_table)
    );

    free_list u_free_list (
        .clock       (clock),
        .reset       (reset),
        .req_count   (req_count),
        .recover     (recover),
        .push        (freed),
        .grant_count (grant_count),
        .free_regs   (free_regs),
        .free_count  (free_count)
    );

    rename_map u_rename_map (
        .clock       (clock),
        .reset       (reset),
        .req         (req),
        .grant_count (grant_count),
        .free_regs   (free_regs),
        .recover     (recover),
        .arch_table  (arch_table),
        .grant       (grant)
    );

endmodule

// ==== tb/rename_unit_tb.sv ====
`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_unit_tb;

    localparam int RESET_CYCLES = 5;
    localparam int SLACK_CYCLES = 20;
    localparam int FREE_COUNT_W = $clog2(`FREE_DEPTH) + 1;

    // one trace line holds the stimulus and the expected outputs of a cycle.
    typedef struct packed {
        logic [8*16-1:0]                           name;
        rename_pkg::rename_req_t                   req;
        retire_pkg::retire_rec_t                   retire;
        logic                                      recover;
        rename_pkg::slot_count_t                   count;
        rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] new_reg;
        rename_pkg::phys_reg_t [`RENAME_WIDTH-1:0] prev_reg;
        logic [FREE_COUNT_W-1:0]                   free_count;
    } trace_entry_t;

    logic                         clock;
    logic                         reset;
    rename_pkg::rename_req_t      req;
    retire_pkg::retire_rec_t      retire;
    logic                         recover;
    rename_pkg::rename_grant_t    grant;
    logic [FREE_COUNT_W-1:0]      free_count;

    trace_entry_t trace_q[$];

    int count_errors  = 0;
    int reg_errors    = 0;
    int free_errors   = 0;
    int format_errors = 0;
    int cycle_count   = 0;
    int cycle_limit   = 0;  // zero until the trace is loaded.

    rename_unit UUT (
        .clock      (clock),
        .reset      (reset),
        .req        (req),
        .retire     (retire),
        .recover    (recover),
        .grant      (grant),
        .free_count (free_count)
    );

    // ==================================================
    // clock and watchdog
    // ==================================================

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the trace did not run to its end", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // ==================================================
    // trace reader
    // ==================================================

    task automatic load_trace();
        int               fd;
        int               fields;
        logic [8*256-1:0] text_line;
        logic [8*16-1:0]  line_name;
        logic [2:0]       req_valid;
        logic [2:0]       ret_valid;
        int               dest0, dest1, dest2;
        int               arch0, phys0, arch1, phys1, arch2, phys2;
        int               rec, cnt, fc;
        int               new0, prev0, new1, prev1, new2, prev2;
        trace_entry_t     entry;
        fd = $fopen("tb/rename_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file tb/rename_trace.txt");
            format_errors++;
        end else begin
            while ($fgets(text_line, fd) != 0) begin
                fields = $sscanf(text_line,
                    "%s %b %d %d %d %b %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    line_name, req_valid, dest0, dest1, dest2,
                    ret_valid, arch0, phys0, arch1, phys1, arch2, phys2, rec,
                    cnt, new0, prev0, new1, prev1, new2, prev2, fc);
                if (fields == 21) begin
                    entry                      = '0;
                    entry.name                 = line_name;
                    entry.req.valid            = req_valid;
                    entry.req.dest[0]          = rename_pkg::arch_reg_t'(dest0);
                    entry.req.dest[1]          = rename_pkg::arch_reg_t'(dest1);
                    entry.req.dest[2]          = rename_pkg::arch_reg_t'(dest2);
                    entry.retire.valid         = ret_valid;
                    entry.retire.slot[0].arch  = rename_pkg::arch_reg_t'(arch0);
                    entry.retire.slot[0].phys  = rename_pkg::phys_reg_t'(phys0);
                    entry.retire.slot[1].arch  = rename_pkg::arch_reg_t'(arch1);
                    entry.retire.slot[1].phys  = rename_pkg::phys_reg_t'(phys1);
                    entry.retire.slot[2].arch  = rename_pkg::arch_reg_t'(arch2);
                    entry.retire.slot[2].phys  = rename_pkg::phys_reg_t'(phys2);
                    entry.recover              = (rec != 0);
                    entry.count                = rename_pkg::slot_count_t'(cnt);
                    entry.new_reg[0]           = rename_pkg::phys_reg_t'(new0);
                    entry.prev_reg[0]          = rename_pkg::phys_reg_t'(prev0);
                    entry.new_reg[1]           = rename_pkg::phys_reg_t'(new1);
                    entry.prev_reg[1]          = rename_pkg::phys_reg_t'(prev1);
                    entry.new_reg[2]           = rename_pkg::phys_reg_t'(new2);
                    entry.prev_reg[2]          = rename_pkg::phys_reg_t'(prev2);
                    entry.free_count           = FREE_COUNT_W'(fc);
                    trace_q.push_back(entry);
                end else if (fields > 1) begin
                    $display("trace line %0s has missing fields and was skipped", line_name);
                    format_errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ==================================================
    // drive and check
    // ==================================================

    task automatic drive_inputs(input trace_entry_t t);
        req     = t.req;
        retire  = t.retire;
        recover = t.recover;
    endtask

    task automatic check_outputs(input trace_entry_t t);
        assert (grant.count == t.count) else begin
            $display("Error: %0s grant count expected %0d actual %0d",
                     t.name, t.count, grant.count);
            count_errors++;
        end
        for (int k = 0; k < `RENAME_WIDTH; k++) begin
            if (k < t.count) begin  // slots past the grant carry nothing.
                assert (grant.slot[k].new_reg == t.new_reg[k]) else begin
                    $display("Error: %0s slot %0d new register expected %0d actual %0d",
                             t.name, k, t.new_reg[k], grant.slot[k].new_reg);
                    reg_errors++;
                end
                assert (grant.slot[k].prev_reg == t.prev_reg[k]) else begin
                    $display("Error: %0s slot %0d previous register expected %0d actual %0d",
                             t.name, k, t.prev_reg[k], grant.slot[k].prev_reg);
                    reg_errors++;
                end
            end
        end
        assert (free_count == t.free_count) else begin
            $display("Error: %0s free count expected %0d actual %0d",
                     t.name, t.free_count, free_count);
            free_errors++;
        end
    endtask

    task automatic report_summary();
        int total;
        total = count_errors + reg_errors + free_errors + format_errors;
        $display("errors: grant count %0d, registers %0d, free count %0d, trace format %0d",
                 count_errors, reg_errors, free_errors, format_errors);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        reset   = 1'b1;
        req     = '0;
        retire  = '0;
        recover = 1'b0;
        load_trace();
        cycle_limit = RESET_CYCLES + trace_q.size() + SLACK_CYCLES;
        if (trace_q.size() == 0) begin
            $display("no usable lines were read from the trace file");
            format_errors++;
        end else begin
            repeat (RESET_CYCLES) @(posedge clock);
            #2;
            reset = 1'b0;
            // outputs settle well before the next edge.
            foreach (trace_q[i]) begin
                drive_inputs(trace_q[i]);
                #15;
                check_outputs(trace_q[i]);
                @(posedge clock);
                #2;
            end
            req     = '0;
            retire  = '0;
            recover = 1'b0;
        end
        report_summary();
    end

endmodule

// ==== tb/rename_trace.txt ====
# name req_valid dest0 dest1 dest2 ret_valid arch0 phys0 arch1 phys1 arch2 phys2 recover
# expected count new0 prev0 new1 prev1 new2 prev2 free_count, valids binary with slot 2 leftmost
# allocation after reset
idle0     000  0  0  0  000  0  0  0  0  0  0  0  0   0  0  0  0  0  0  32
alloc0    111  1  2  3  000  0  0  0  0  0  0  0  3  32  1 33  2 34  3  32
alloc1    111  4  5  6  000  0  0  0  0  0  0  0  3  35  4 36  5 37  6  29
alloc2    111  7  8  9  000  0  0  0  0  0  0  0  3  38  7 39  8 40  9  26
# same destination twice within a group
bypass0   111  1  1  2  000  0  0  0  0  0  0  0  3  41 32 42 41 43 33  23
bypass1   111  1  2  1  000  0  0  0  0  0  0  0  3  44 42 45 43 46 44  20
bypass2   111  3  3  3  000  0  0  0  0  0  0  0  3  47 34 48 47 49 48  17
newest0   011  1  3  0  000  0  0  0  0  0  0  0  2  50 46 51 49  0  0  14
# drain the free list down to a partial grant
drain0    111 10 11 12  000  0  0  0  0  0  0  0  3  52 10 53 11 54 12  12
drain1    111 13 14 15  000  0  0  0  0  0  0  0  3  55 13 56 14 57 15   9
drain2    111 16 17 18  000  0  0  0  0  0  0  0  3  58 16 59 17 60 18   6
single0   001 19  0  0  000  0  0  0  0  0  0  0  1  61 19  0  0  0  0   3
partial0  111 20 21 22  000  0  0  0  0  0  0  0  2  62 20 63 21  0  0   2
empty0    111 22 23 24  000  0  0  0  0  0  0  0  0   0  0  0  0  0  0   0
# retirement hands displaced registers back
retire0   000  0  0  0  111  1 32  2 33  3 34  0  0   0  0  0  0  0  0   0
reuse0    111 22 23 24  111  4 35  5 36  6 37  0  3   1 22  2 23  3 24   3
reuse1    111 25 26 27  000  0  0  0  0  0  0  0  3   4 25  5 26  6 27   3
retire1   000  0  0  0  111  7 38  8 39  9 40  0  0   0  0  0  0  0  0   0
retire2   111 28 29 30  111  1 41  1 42  2 43  0  3   7 28  8 29  9 30   3
reuse2    011 31  0  0  000  0  0  0  0  0  0  0  2  32 31 41  0  0  0   3
# recovery rolls back every allocation since the last retirement
recover0  111  1  2  3  000  0  0  0  0  0  0  1  0   0  0  0  0  0  0   1
rollback0 111  1  2  3  000  0  0  0  0  0  0  0  3  44 42 45 43 46 34  32
rollback1 111  4  4  9  000  0  0  0  0  0  0  0  3  47 35 48 47 49 40  29
rollback2 001 22  0  0  000  0  0  0  0  0  0  0  1  50 22  0  0  0  0  26
retire3   111  5  6  7  111  1 44  2 45  3 46  0  3  51 36 52 37 53 38  25
idle1     000  0  0  0  000  0  0  0  0  0  0  0  0   0  0  0  0  0  0  25

// ==== sim.f ====
+incdir+logic
logic/rename_pkg.sv
logic/retire_pkg.sv
logic/free_list.sv
logic/commit_map.sv
logic/rename_map.sv
logic/rename_unit.sv
tb/rename_unit_tb.sv

// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/rename_pkg.sv
      - logic/retire_pkg.sv
      - logic/free_list.sv
      - logic/commit_map.sv
      - logic/rename_map.sv
      - logic/rename_unit.sv

  - target: test
    include_dirs:
      - logic
    files:
      - tb/rename_unit_tb.sv
